/* flist.f */
+incdir+common
common/soc_pkg.sv
hdl/addr_decode.sv
l2mem/l2_mem.sv
uart/apb_bridge.sv
ctrl/ctrl_regs.sv
hdl/rsp_collect.sv
hdl/soc_top.sv
bench/tb_clk_gen.sv
bench/soc_assert.sv
bench/tb_soc.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     = --timing --assert
TOP       = tb_soc
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors
PASS_MSG  = Finished with no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qx "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_soc.sv */
//////////////////////////////////////////////////
// SoC memory system testbench
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module tb_soc;

  localparam int RSP_TIMEOUT = 50;
  localparam int RST_TIMEOUT = 20;

  // One table row: request, expected response, expected outputs
  typedef struct packed {
    logic           write;
    soc_pkg::addr_t addr;
    soc_pkg::data_t wdata;
    soc_pkg::strb_t strb;
    soc_pkg::data_t rdata;
    logic           err;
    soc_pkg::data_t exit_val;
    soc_pkg::data_t cnt_val;
    int             lat;
  } vec_t;

  logic               clk_i;
  logic               rst_n_i;
  logic               req_valid_i    = 1'b0;
  soc_pkg::bus_req_t  req_i          = '0;
  soc_pkg::apb_data_t uart_prdata_i  = '0;
  logic               uart_pready_i  = 1'b0;
  logic               uart_pslverr_i = 1'b0;

  logic               rsp_valid_o;
  soc_pkg::bus_rsp_t  rsp_o;
  soc_pkg::data_t     exit_o;
  soc_pkg::data_t     hw_cnt_en_o;
  logic               uart_psel_o;
  logic               uart_penable_o;
  logic               uart_pwrite_o;
  soc_pkg::apb_addr_t uart_paddr_o;
  soc_pkg::apb_data_t uart_pwdata_o;

  integer             seed         = 33387;
  int                 value_errs   = 0;
  int                 timeout_errs = 0;
  int                 apb_wait     = 0;
  int                 apb_xfers    = 0;
  logic               seen_pwrite;
  soc_pkg::apb_addr_t seen_paddr;
  soc_pkg::apb_data_t seen_pwdata;
  soc_pkg::data_t     exit_m       = '0;
  soc_pkg::data_t     cnt_m        = '0;
  vec_t               vectors[$];

  tb_clk_gen i_clk_gen (
    .clk_o  (clk_i  ),
    .rst_n_o(rst_n_i)
  );

  soc_top i_dut (
    .clk_i         (clk_i         ),
    .rst_n_i       (rst_n_i       ),
    .req_valid_i   (req_valid_i   ),
    .req_i         (req_i         ),
    .rsp_valid_o   (rsp_valid_o   ),
    .rsp_o         (rsp_o         ),
    .exit_o        (exit_o        ),
    .hw_cnt_en_o   (hw_cnt_en_o   ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i)
  );

  //////////////////////////////////////////////////
  // APB responder
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (uart_psel_o && !uart_penable_o) begin
      apb_wait = {$random(seed)} % 4;
      uart_pready_i <= 1'b0;
    end else if (uart_psel_o && uart_penable_o) begin
      apb_xfers   <= apb_xfers + 1;
      seen_pwrite <= uart_pwrite_o;
      seen_paddr  <= uart_paddr_o;
      seen_pwdata <= uart_pwdata_o;
      if (apb_wait == 0) begin
        uart_pready_i <= 1'b1;
      end else begin
        uart_pready_i <= 1'b0;
        apb_wait = apb_wait - 1;
      end
    end else begin
      uart_pready_i <= 1'b0;
    end
    uart_prdata_i  <= uart_paddr_o ^ 32'h5A5A_5A5A;
    uart_pslverr_i <= uart_psel_o && (uart_paddr_o[11:0] == 12'hFFC);
  end

  //////////////////////////////////////////////////
  // Reference rules
  //////////////////////////////////////////////////

  function automatic soc_pkg::data_t merge_bytes(soc_pkg::data_t old_w, soc_pkg::data_t new_w,
                                                 soc_pkg::strb_t strb);
    soc_pkg::data_t mask;
    mask = '0;
    for (int b = 0; b < 8; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic soc_pkg::addr_t l2_addr(int k);
    soc_pkg::addr_t word;
    word = (64'(k) * 64'd173 + 64'd7) % 64'(`L2_NUM_WORDS);
    return `DRAM_BASE + 64'd8 * word;
  endfunction

  // Responder rule, zero-extended
  function automatic soc_pkg::data_t uart_rd(soc_pkg::addr_t a);
    return {32'h0, a[31:0] ^ 32'h5A5A_5A5A};
  endfunction

  function automatic logic is_uart(soc_pkg::addr_t a);
    return (a >= `UART_BASE) && (a < `UART_BASE + `UART_LEN);
  endfunction

  task automatic add_vec(input logic write, input soc_pkg::addr_t addr,
                         input soc_pkg::data_t wdata, input soc_pkg::strb_t strb,
                         input soc_pkg::data_t rdata, input logic err, input int lat);
    vec_t v;
    v = '{write: write, addr: addr, wdata: wdata, strb: strb, rdata: rdata, err: err,
          exit_val: exit_m, cnt_val: cnt_m, lat: lat};
    vectors.push_back(v);
  endtask

  task automatic build_vectors();
    soc_pkg::data_t shadow [6];
    soc_pkg::strb_t part   [6];
    soc_pkg::data_t d;
    part = '{8'h0F, 8'hF0, 8'h81, 8'h3C, 8'h01, 8'hAA};
    // L2 full writes, readback, partial rewrites
    for (int k = 0; k < 6; k++) begin
      shadow[k] = {$random(seed), $random(seed)};
      add_vec(1'b1, l2_addr(k), shadow[k], 8'hFF, '0, 1'b0, 3);
    end
    for (int k = 0; k < 6; k++) begin
      add_vec(1'b0, l2_addr(k), '0, '0, shadow[k], 1'b0, 3);
    end
    for (int k = 0; k < 6; k++) begin
      d         = {$random(seed), $random(seed)};
      shadow[k] = merge_bytes(shadow[k], d, part[k]);
      add_vec(1'b1, l2_addr(k), d, part[k], '0, 1'b0, 3);
      add_vec(1'b0, l2_addr(k), '0, '0, shadow[k], 1'b0, 3);
    end
    // Control registers
    exit_m = merge_bytes(exit_m, 64'h0123_4567_89AB_CDEF, 8'hFF);
    add_vec(1'b1, `CTRL_BASE, 64'h0123_4567_89AB_CDEF, 8'hFF, '0, 1'b0, 3);
    add_vec(1'b0, `CTRL_BASE, '0, '0, exit_m, 1'b0, 3);
    cnt_m = merge_bytes(cnt_m, 64'hFFEE_DDCC_BBAA_9988, 8'h0F);
    add_vec(1'b1, `CTRL_BASE + 64'h8, 64'hFFEE_DDCC_BBAA_9988, 8'h0F, '0, 1'b0, 3);
    exit_m = merge_bytes(exit_m, 64'h0, 8'h30);
    add_vec(1'b1, `CTRL_BASE, 64'h0, 8'h30, '0, 1'b0, 3);
    add_vec(1'b0, `CTRL_BASE + 64'h8, '0, '0, cnt_m, 1'b0, 3);
    add_vec(1'b0, `CTRL_BASE, '0, '0, exit_m, 1'b0, 3);
    add_vec(1'b1, `CTRL_BASE + 64'h10, '1, 8'hFF, '0, 1'b1, 3);
    add_vec(1'b0, `CTRL_BASE + 64'h10, '0, '0, '0, 1'b1, 3);
    // UART through the APB bridge, variable latency
    add_vec(1'b1, `UART_BASE + 64'h10, 64'hDEAD_BEEF_1234_5678, 8'hFF, '0, 1'b0, 0);
    add_vec(1'b0, `UART_BASE + 64'h20, '0, '0, uart_rd(`UART_BASE + 64'h20), 1'b0, 0);
    add_vec(1'b0, `UART_BASE + 64'h104, '0, '0, uart_rd(`UART_BASE + 64'h104), 1'b0, 0);
    add_vec(1'b1, `UART_BASE + 64'hFFC, 64'h55, 8'hFF, '0, 1'b1, 0);
    add_vec(1'b0, `UART_BASE + 64'h8, '0, '0, uart_rd(`UART_BASE + 64'h8), 1'b0, 0);
    // Unmapped
    add_vec(1'b0, 64'h1000_0000, '0, '0, '0, 1'b1, 2);
    add_vec(1'b1, 64'h1000_0000, '1, 8'hFF, '0, 1'b1, 2);
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic check_idle();
    assert (rsp_valid_o == 1'b0) else begin
      $display("ERR rsp_valid_o: got %h exp %h", rsp_valid_o, 1'b0);
      value_errs++;
    end
    assert (uart_psel_o == 1'b0) else begin
      $display("ERR uart_psel_o: got %h exp %h", uart_psel_o, 1'b0);
      value_errs++;
    end
    assert (uart_penable_o == 1'b0) else begin
      $display("ERR uart_penable_o: got %h exp %h", uart_penable_o, 1'b0);
      value_errs++;
    end
    assert (exit_o == '0) else begin
      $display("ERR exit_o: got %h exp %h", exit_o, 64'h0);
      value_errs++;
    end
    assert (hw_cnt_en_o == '0) else begin
      $display("ERR hw_cnt_en_o: got %h exp %h", hw_cnt_en_o, 64'h0);
      value_errs++;
    end
  endtask

  task automatic run_vector(input int n, input vec_t v);
    int   cycles;
    int   xfers_before;
    logic got;
    cycles       = 0;
    got          = 1'b0;
    xfers_before = apb_xfers;
    @(negedge clk_i);
    req_i       = '{write: v.write, addr: v.addr, wdata: v.wdata, strb: v.strb};
    req_valid_i = 1'b1;
    while (!got && cycles < RSP_TIMEOUT) begin
      @(negedge clk_i);
      req_valid_i = 1'b0;
      cycles++;
      got = rsp_valid_o;
    end
    assert (got) else begin
      $display("Request %0d got no response within %0d cycles", n, RSP_TIMEOUT);
      timeout_errs++;
    end
    if (got) begin
      assert (rsp_o.rdata == v.rdata) else begin
        $display("ERR rsp_o.rdata: got %h exp %h (request %0d)", rsp_o.rdata, v.rdata, n);
        value_errs++;
      end
      assert (rsp_o.err == v.err) else begin
        $display("ERR rsp_o.err: got %h exp %h (request %0d)", rsp_o.err, v.err, n);
        value_errs++;
      end
      if (v.lat != 0) begin
        assert (cycles == v.lat) else begin
          $display("ERR rsp_valid_o latency: got %h exp %h (request %0d)", cycles, v.lat, n);
          value_errs++;
        end
      end
      assert (exit_o == v.exit_val) else begin
        $display("ERR exit_o: got %h exp %h (request %0d)", exit_o, v.exit_val, n);
        value_errs++;
      end
      assert (hw_cnt_en_o == v.cnt_val) else begin
        $display("ERR hw_cnt_en_o: got %h exp %h (request %0d)", hw_cnt_en_o, v.cnt_val, n);
        value_errs++;
      end
      if (is_uart(v.addr)) begin
        assert (apb_xfers != xfers_before) else begin
          $display("Request %0d produced no APB access phase", n);
          value_errs++;
        end
        assert (seen_paddr == v.addr[31:0]) else begin
          $display("ERR uart_paddr_o: got %h exp %h", seen_paddr, v.addr[31:0]);
          value_errs++;
        end
        assert (seen_pwrite == v.write) else begin
          $display("ERR uart_pwrite_o: got %h exp %h", seen_pwrite, v.write);
          value_errs++;
        end
        if (v.write) begin
          assert (seen_pwdata == v.wdata[31:0]) else begin
            $display("ERR uart_pwdata_o: got %h exp %h", seen_pwdata, v.wdata[31:0]);
            value_errs++;
          end
        end
      end
    end
  endtask

  initial begin
    int n;
    n = 0;
    while (rst_n_i !== 1'b1 && n < RST_TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    assert (rst_n_i === 1'b1) else begin
      $display("Reset was not released within %0d cycles", RST_TIMEOUT);
      timeout_errs++;
    end
    @(negedge clk_i);
    check_idle();
    build_vectors();
    for (int i = 0; i < vectors.size(); i++) begin
      run_vector(i, vectors[i]);
    end
    $display("Checked %0d requests: %0d value errors, %0d timeouts",
             vectors.size(), value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/soc_assert.sv */
//////////////////////////////////////////////////
// Handshake and APB assertions
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module soc_assert (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_valid_i,
  input logic rsp_valid_i,
  input logic psel_i,
  input logic penable_i
);

  logic pending;

  // One request in flight until its response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending <= 1'b0;
    end else if (req_valid_i) begin
      pending <= 1'b1;
    end else if (rsp_valid_i) begin
      pending <= 1'b0;
    end
  end

  a_rsp_pulse : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i |=> !rsp_valid_i)
    else $error("Response strobe high in two consecutive cycles");

  a_apb_setup : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(penable_i) |-> $past(psel_i && !penable_i))
    else $error("APB enable rose without a setup cycle");

  a_one_outstanding : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> (!pending || rsp_valid_i))
    else $error("New request while a response is outstanding");

endmodule

bind soc_top soc_assert i_soc_assert (
  .clk_i      (clk_i         ),
  .rst_n_i    (rst_n_i       ),
  .req_valid_i(req_valid_i   ),
  .rsp_valid_i(rsp_valid_o   ),
  .psel_i     (uart_psel_o   ),
  .penable_i  (uart_penable_o)
);

`default_nettype wire

/* bench/tb_clk_gen.sv */
//////////////////////////////////////////////////
// Testbench clock and reset
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* hdl/soc_top.sv */
//////////////////////////////////////////////////
// SoC memory system top
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module soc_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_valid_i,
  input  soc_pkg::bus_req_t   req_i,
  output logic                rsp_valid_o,
  output soc_pkg::bus_rsp_t   rsp_o,
  output soc_pkg::data_t      exit_o,
  output soc_pkg::data_t      hw_cnt_en_o,
  // UART APB port
  output logic                uart_psel_o,
  output logic                uart_penable_o,
  output logic                uart_pwrite_o,
  output soc_pkg::apb_addr_t  uart_paddr_o,
  output soc_pkg::apb_data_t  uart_pwdata_o,
  input  soc_pkg::apb_data_t  uart_prdata_i,
  input  logic                uart_pready_i,
  input  logic                uart_pslverr_i
);

  soc_pkg::bus_req_t dec_req;
  logic              l2_sel;
  logic              uart_sel;
  logic              ctrl_sel;
  logic              dec_err;

  logic              l2_valid;
  logic              uart_valid;
  logic              ctrl_valid;
  soc_pkg::bus_rsp_t l2_rsp;
  soc_pkg::bus_rsp_t uart_rsp;
  soc_pkg::bus_rsp_t ctrl_rsp;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  addr_decode i_addr_decode (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .req_valid_i(req_valid_i),
    .req_i      (req_i      ),
    .req_o      (dec_req    ),
    .l2_sel_o   (l2_sel     ),
    .uart_sel_o (uart_sel   ),
    .ctrl_sel_o (ctrl_sel   ),
    .dec_err_o  (dec_err    )
  );

  //////////////////////////////////////////////////
  // Targets
  //////////////////////////////////////////////////

  l2_mem i_l2_mem (
    .clk_i      (clk_i   ),
    .rst_n_i    (rst_n_i ),
    .sel_i      (l2_sel  ),
    .req_i      (dec_req ),
    .rsp_valid_o(l2_valid),
    .rsp_o      (l2_rsp  )
  );

  apb_bridge i_apb_bridge (
    .clk_i      (clk_i         ),
    .rst_n_i    (rst_n_i       ),
    .sel_i      (uart_sel      ),
    .req_i      (dec_req       ),
    .psel_o     (uart_psel_o   ),
    .penable_o  (uart_penable_o),
    .pwrite_o   (uart_pwrite_o ),
    .paddr_o    (uart_paddr_o  ),
    .pwdata_o   (uart_pwdata_o ),
    .prdata_i   (uart_prdata_i ),
    .pready_i   (uart_pready_i ),
    .pslverr_i  (uart_pslverr_i),
    .rsp_valid_o(uart_valid    ),
    .rsp_o      (uart_rsp      )
  );

  ctrl_regs i_ctrl_regs (
    .clk_i      (clk_i      ),
    .rst_n_i    (rst_n_i    ),
    .sel_i      (ctrl_sel   ),
    .req_i      (dec_req    ),
    .exit_o     (exit_o     ),
    .hw_cnt_en_o(hw_cnt_en_o),
    .rsp_valid_o(ctrl_valid ),
    .rsp_o      (ctrl_rsp   )
  );

  //////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////

  rsp_collect i_rsp_collect (
    .clk_i       (clk_i      ),
    .rst_n_i     (rst_n_i    ),
    .l2_valid_i  (l2_valid   ),
    .l2_rsp_i    (l2_rsp     ),
    .uart_valid_i(uart_valid ),
    .uart_rsp_i  (uart_rsp   ),
    .ctrl_valid_i(ctrl_valid ),
    .ctrl_rsp_i  (ctrl_rsp   ),
    .dec_err_i   (dec_err    ),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o      )
  );

endmodule

`default_nettype wire

/* hdl/rsp_collect.sv */
//////////////////////////////////////////////////
// Response collector
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module rsp_collect (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              l2_valid_i,
  input  soc_pkg::bus_rsp_t l2_rsp_i,
  input  logic              uart_valid_i,
  input  soc_pkg::bus_rsp_t uart_rsp_i,
  input  logic              ctrl_valid_i,
  input  soc_pkg::bus_rsp_t ctrl_rsp_i,
  input  logic              dec_err_i,
  output logic              rsp_valid_o,
  output soc_pkg::bus_rsp_t rsp_o
);

  logic              any_valid;
  soc_pkg::bus_rsp_t rsp_sel;

  assign any_valid = l2_valid_i || uart_valid_i || ctrl_valid_i || dec_err_i;

  // Only one source is active at a time
  always_comb begin
    if (l2_valid_i) begin
      rsp_sel = l2_rsp_i;
    end else if (uart_valid_i) begin
      rsp_sel = uart_rsp_i;
    end else if (ctrl_valid_i) begin
      rsp_sel = ctrl_rsp_i;
    end else begin
      // Decode error
      rsp_sel = '{rdata: '0, err: 1'b1};
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= any_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (any_valid) begin
      rsp_o <= rsp_sel;
    end
  end

endmodule

`default_nettype wire

/* ctrl/ctrl_regs.sv */
//////////////////////////////////////////////////
// Control registers
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module ctrl_regs (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              sel_i,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::data_t    exit_o,
  output soc_pkg::data_t    hw_cnt_en_o,
  output logic              rsp_valid_o,
  output soc_pkg::bus_rsp_t rsp_o
);

  soc_pkg::addr_t ofs;
  logic           hit_exit;
  logic           hit_cnt_en;
  soc_pkg::data_t rdata;

  assign ofs        = req_i.addr - `CTRL_BASE;
  assign hit_exit   = (ofs == `CTRL_EXIT_OFS);
  assign hit_cnt_en = (ofs == `CTRL_CNT_EN_OFS);
  assign rdata      = hit_exit ? exit_o : hw_cnt_en_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_o      <= '0;
      hw_cnt_en_o <= '0;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= sel_i;
      if (sel_i && req_i.write && hit_exit) begin
        exit_o <= soc_pkg::apply_strb(exit_o, req_i.wdata, req_i.strb);
      end
      if (sel_i && req_i.write && hit_cnt_en) begin
        hw_cnt_en_o <= soc_pkg::apply_strb(hw_cnt_en_o, req_i.wdata, req_i.strb);
      end
    end
  end

  // Unknown offset answers with an error and zero data
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (hit_exit || hit_cnt_en) begin
        rsp_o <= '{rdata: req_i.write ? '0 : rdata, err: 1'b0};
      end else begin
        rsp_o <= '{rdata: '0, err: 1'b1};
      end
    end
  end

endmodule

`default_nettype wire

/* uart/apb_bridge.sv */
//////////////////////////////////////////////////
// APB bridge
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module apb_bridge (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               sel_i,
  input  soc_pkg::bus_req_t  req_i,
  output logic               psel_o,
  output logic               penable_o,
  output logic               pwrite_o,
  output soc_pkg::apb_addr_t paddr_o,
  output soc_pkg::apb_data_t pwdata_o,
  input  soc_pkg::apb_data_t prdata_i,
  input  logic               pready_i,
  input  logic               pslverr_i,
  output logic               rsp_valid_o,
  output soc_pkg::bus_rsp_t  rsp_o
);

  soc_pkg::apb_state_e state_q;
  logic                accept;
  logic                done;

  assign accept = (state_q == soc_pkg::APB_IDLE) && sel_i;
  assign done   = (state_q == soc_pkg::APB_ACCESS) && pready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= soc_pkg::APB_IDLE;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= done;
      case (state_q)
        soc_pkg::APB_IDLE: begin
          if (sel_i) begin
            state_q <= soc_pkg::APB_SETUP;
          end
        end
        soc_pkg::APB_SETUP: begin
          state_q <= soc_pkg::APB_ACCESS;
        end
        soc_pkg::APB_ACCESS: begin
          // Hold access until the slave is ready
          if (pready_i) begin
            state_q <= soc_pkg::APB_IDLE;
          end
        end
        default: begin
          state_q <= soc_pkg::APB_IDLE;
        end
      endcase
    end
  end

  // Transfer fields, held for the whole transfer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pwrite_o <= req_i.write;
      paddr_o  <= req_i.addr[`APB_W-1:0];
      pwdata_o <= req_i.wdata[`APB_W-1:0];
    end
  end

  // Read data zero-extended to the bus width
  always_ff @(posedge clk_i) begin
    if (done) begin
      rsp_o.rdata <= pwrite_o ? '0 : soc_pkg::data_t'(prdata_i);
      rsp_o.err   <= pslverr_i;
    end
  end

  assign psel_o    = (state_q != soc_pkg::APB_IDLE);
  assign penable_o = (state_q == soc_pkg::APB_ACCESS);

endmodule

`default_nettype wire

/* l2mem/l2_mem.sv */
//////////////////////////////////////////////////
// L2 memory
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module l2_mem (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              sel_i,
  input  soc_pkg::bus_req_t req_i,
  output logic              rsp_valid_o,
  output soc_pkg::bus_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(`L2_NUM_WORDS);

  soc_pkg::data_t   mem [`L2_NUM_WORDS];
  soc_pkg::data_t   rdata_q;
  logic [IDX_W-1:0] idx;

  // Word index from the byte offset
  assign idx = IDX_W'((req_i.addr - `DRAM_BASE) >> 3);

  always_ff @(posedge clk_i) begin
    if (sel_i && req_i.write) begin
      mem[idx] <= soc_pkg::apply_strb(mem[idx], req_i.wdata, req_i.strb);
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_q <= req_i.write ? '0 : mem[idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= sel_i;
    end
  end

  assign rsp_o = '{rdata: rdata_q, err: 1'b0};

endmodule

`default_nettype wire

/* hdl/addr_decode.sv */
//////////////////////////////////////////////////
// Address decoder
//////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module addr_decode (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_valid_i,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_req_t req_o,
  output logic              l2_sel_o,
  output logic              uart_sel_o,
  output logic              ctrl_sel_o,
  output logic              dec_err_o
);

  logic hit_l2;
  logic hit_uart;
  logic hit_ctrl;

  function automatic logic in_region(soc_pkg::addr_t addr, soc_pkg::addr_t base,
                                     soc_pkg::addr_t len);
    return (addr >= base) && (addr < base + len);
  endfunction

  assign hit_l2   = in_region(req_i.addr, `DRAM_BASE, `DRAM_LEN);
  assign hit_uart = in_region(req_i.addr, `UART_BASE, `UART_LEN);
  assign hit_ctrl = in_region(req_i.addr, `CTRL_BASE, `CTRL_LEN);

  // One strobe per request, at most one high
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      l2_sel_o   <= 1'b0;
      uart_sel_o <= 1'b0;
      ctrl_sel_o <= 1'b0;
      dec_err_o  <= 1'b0;
    end else begin
      l2_sel_o   <= req_valid_i && hit_l2;
      uart_sel_o <= req_valid_i && hit_uart;
      ctrl_sel_o <= req_valid_i && hit_ctrl;
      dec_err_o  <= req_valid_i && !(hit_l2 || hit_uart || hit_ctrl);
    end
  end

  // Request payload, shared by all targets
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req_o <= req_i;
    end
  end

endmodule

`default_nettype wire

/* common/soc_pkg.sv */
//////////////////////////////////////////////////
// SoC bus types
//////////////////////////////////////////////////

`default_nettype none

`include "soc_params.svh"

package soc_pkg;

  typedef logic [`SOC_ADDR_W-1:0]   addr_t;
  typedef logic [`SOC_DATA_W-1:0]   data_t;
  typedef logic [`SOC_DATA_W/8-1:0] strb_t;
  typedef logic [`APB_W-1:0]        apb_addr_t;
  typedef logic [`APB_W-1:0]        apb_data_t;

  // Single request, qualified by a separate valid strobe
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  // Byte-wise merge of a write into a stored word
  function automatic data_t apply_strb(data_t old_word, data_t new_word, strb_t strb);
    data_t merged;
    merged = old_word;
    for (int i = 0; i < $bits(strb_t); i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

/* common/soc_params.svh */
//////////////////////////////////////////////////
// SoC memory map and widths
//////////////////////////////////////////////////

`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define SOC_ADDR_W 64
`define SOC_DATA_W 64
`define APB_W      32

// L2 depth in 64-bit words
`define L2_NUM_WORDS 1024

// Memory map
`define DRAM_BASE 64'h0000_0000_8000_0000
`define DRAM_LEN  (64'd8 * `L2_NUM_WORDS)
`define UART_BASE 64'h0000_0000_C000_0000
`define UART_LEN  64'h0000_0000_0000_1000
`define CTRL_BASE 64'h0000_0000_D000_0000
`define CTRL_LEN  64'h0000_0000_0000_1000

// Control register offsets
`define CTRL_EXIT_OFS   64'h0
`define CTRL_CNT_EN_OFS 64'h8

`endif
